// ==== Makefile ====
TOP   := tb_burst_rx
FLIST := burst_rx.f

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f $(FLIST)

sim:
	verilator --binary --assert -j 0 --top-module $(TOP) -Mdir obj_dir -f $(FLIST)
	out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir

// ==== burst_rx.f ====
hdl/xgpon_frame_pkg.sv
hdl/rx_stream_pkg.sv
hdl/burst_rx_if.sv
hdl/preamble_correlator.sv
hdl/burst_word_counter.sv
hdl/burst_fsm.sv
hdl/rx_stream_fifo.sv
hdl/burst_rx_top.sv
tests/burst_rx_assertions.sv
tests/tb_burst_rx.sv

// ==== hdl/burst_fsm.sv ====
module burst_fsm (
  input  logic                        axis_aclk_gt_rx_usrclk,
  input  logic                        rst_n,
  corr_if.sink                        corr,
  count_if.ctrl                       cnt,
  output logic                        wr_en,       // payload word into the fifo
  output rx_stream_pkg::stream_beat_t wr_beat,
  output logic                        burst_start  // one cycle per accepted delimiter
);

  typedef enum logic [1:0] {
    st_hunt,       // looking for the first preamble word
    st_preamble,   // counting the preamble run
    st_delimiter,  // armed, waiting for the delimiter
    st_payload     // passing payload words to the fifo
  } state_t;

  state_t state;
  state_t state_next;
  logic   start_next;

  // ------------------------------------------------------------------------
  // next state and counter control
  // ------------------------------------------------------------------------
  always_comb begin
    state_next     = state;
    start_next     = 1'b0;
    cnt.load       = 1'b0;
    cnt.load_value = xgpon_frame_pkg::preamble_load;
    cnt.tick       = 1'b0;
    case (state)
      st_hunt: begin
        if (corr.preamble_hit) begin    // hit already implies word_valid
          cnt.load   = 1'b1;
          state_next = st_preamble;
        end
      end
      st_preamble: begin
        // an idle or corrupted word breaks the run
        if (!corr.preamble_hit) begin
          state_next = st_hunt;
        end else if (cnt.done) begin
          cnt.load       = 1'b1;
          cnt.load_value = xgpon_frame_pkg::delim_load;
          state_next     = st_delimiter;
        end else begin
          cnt.tick = 1'b1;
        end
      end
      st_delimiter: begin
        if (corr.word_valid) begin
          if (corr.delim_hit) begin
            start_next     = 1'b1;
            cnt.load       = 1'b1;
            cnt.load_value = xgpon_frame_pkg::payload_load;
            state_next     = st_payload;
          end else if (cnt.done) begin
            state_next = st_hunt;       // window ran out
          end else begin
            cnt.tick = 1'b1;
          end
        end
      end
      st_payload: begin
        if (corr.word_valid) begin
          cnt.tick = 1'b1;
          if (cnt.done) state_next = st_hunt; // that was the last word
        end
      end
      default: state_next = st_hunt;
    endcase
  end

  // ------------------------------------------------------------------------
  // state and start pulse
  // ------------------------------------------------------------------------
  always_ff @(posedge axis_aclk_gt_rx_usrclk or negedge rst_n) begin
    if (!rst_n) begin
      state       <= st_hunt;
      burst_start <= 1'b0;
    end else begin
      state       <= state_next;
      burst_start <= start_next;
    end
  end

  // write port straight off the correlator stage, fifo registers it
  assign wr_en   = corr.word_valid && (state == st_payload);
  assign wr_beat = '{data: corr.word, last: cnt.done};

endmodule

// ==== hdl/burst_rx_if.sv ====
// correlator to framing fsm, one registered word per cycle
interface corr_if;

  rx_stream_pkg::line_word_t word;   // delayed copy of rx_data
  logic                      word_valid;   // gt rx active, same stage as word
  logic                      preamble_hit; // within threshold of sync word
  logic                      delim_hit;    // exact delimiter

  modport source (
    output word, word_valid, preamble_hit, delim_hit
  );

  modport sink (
    input word, word_valid, preamble_hit, delim_hit
  );

endinterface

// framing fsm to the phase counter
interface count_if;

  logic                                   load;
  logic [xgpon_frame_pkg::count_width-1:0] load_value;
  logic                                   tick;  // step down by one
  logic                                   done;  // count is zero

  modport ctrl (
    output load, load_value, tick,
    input  done
  );

  modport timer (
    input  load, load_value, tick,
    output done
  );

endinterface

// ==== hdl/burst_rx_top.sv ====
module burst_rx_top (
  input  logic                      axis_aclk_gt_rx_usrclk,
  input  logic                      rst_n,
  // raw transceiver side
  input  rx_stream_pkg::line_word_t rx_data,
  input  logic                      rx_valid,
  // payload stream out
  output rx_stream_pkg::line_word_t m_tdata,
  output logic                      m_tlast,
  output logic                      m_tvalid,
  input  logic                      m_tready,
  // status
  output logic                      burst_start,
  output logic                      overflow
);

  corr_if  corr ();
  count_if cnt ();

  logic                        wr_en;
  rx_stream_pkg::stream_beat_t wr_beat;

  // ------------------------------------------------------------------------
  // preamble / delimiter detect
  // ------------------------------------------------------------------------
  preamble_correlator u_correlator (
    .axis_aclk_gt_rx_usrclk (axis_aclk_gt_rx_usrclk),
    .rst_n                  (rst_n),
    .rx_data                (rx_data),
    .rx_valid               (rx_valid),
    .corr                   (corr.source)
  );

  // ------------------------------------------------------------------------
  // framing and phase timing
  // ------------------------------------------------------------------------
  burst_fsm u_fsm (
    .axis_aclk_gt_rx_usrclk (axis_aclk_gt_rx_usrclk),
    .rst_n                  (rst_n),
    .corr                   (corr.sink),
    .cnt                    (cnt.ctrl),
    .wr_en                  (wr_en),
    .wr_beat                (wr_beat),
    .burst_start            (burst_start)
  );

  burst_word_counter u_counter (
    .axis_aclk_gt_rx_usrclk (axis_aclk_gt_rx_usrclk),
    .rst_n                  (rst_n),
    .cnt                    (cnt.timer)
  );

  // ------------------------------------------------------------------------
  // output buffer
  // ------------------------------------------------------------------------
  rx_stream_fifo u_fifo (
    .axis_aclk_gt_rx_usrclk (axis_aclk_gt_rx_usrclk),
    .rst_n                  (rst_n),
    .wr_en                  (wr_en),
    .wr_beat                (wr_beat),
    .m_tdata                (m_tdata),
    .m_tlast                (m_tlast),
    .m_tvalid               (m_tvalid),
    .m_tready               (m_tready),
    .overflow               (overflow)
  );

endmodule

// ==== hdl/burst_word_counter.sv ====
module burst_word_counter (
  input  logic    axis_aclk_gt_rx_usrclk,
  input  logic    rst_n,
  count_if.timer  cnt
);

  logic [xgpon_frame_pkg::count_width-1:0] count;

  // ------------------------------------------------------------------------
  // down-counter, load wins over tick, holds at zero
  // ------------------------------------------------------------------------
  always_ff @(posedge axis_aclk_gt_rx_usrclk or negedge rst_n) begin
    if (!rst_n) begin
      count <= '0;
    end else if (cnt.load) begin
      count <= cnt.load_value;       // new phase
    end else if (cnt.tick && count != '0) begin
      count <= count - 1'b1;
    end
  end

  // phases never overlap so one done serves preamble, window and payload
  assign cnt.done = (count == '0);

endmodule

// ==== hdl/preamble_correlator.sv ====
module preamble_correlator (
  input  logic                      axis_aclk_gt_rx_usrclk,
  input  logic                      rst_n,
  input  rx_stream_pkg::line_word_t rx_data,
  input  logic                      rx_valid,  // gt rx active
  corr_if.source                    corr
);

  logic [xgpon_frame_pkg::dist_width-1:0] bit_err; // hamming distance to sync word

  // count ones in the xor pattern
  function automatic logic [xgpon_frame_pkg::dist_width-1:0] count_ones(
    input rx_stream_pkg::line_word_t w
  );
    logic [xgpon_frame_pkg::dist_width-1:0] n;
    n = '0;
    for (int i = 0; i < xgpon_frame_pkg::word_width; i++) begin
      if (w[i]) n = n + 1'b1;
    end
    return n;
  endfunction

  assign bit_err = count_ones(rx_data ^ xgpon_frame_pkg::sync_word);

  // ------------------------------------------------------------------------
  // one register stage, word and flags stay aligned
  // ------------------------------------------------------------------------
  always_ff @(posedge axis_aclk_gt_rx_usrclk or negedge rst_n) begin
    if (!rst_n) begin
      corr.word_valid   <= 1'b0;
      corr.preamble_hit <= 1'b0;
      corr.delim_hit    <= 1'b0;
    end else begin
      corr.word_valid   <= rx_valid;
      // hits only count on an active word, so downstream never sees a stale hit
      corr.preamble_hit <= rx_valid && (bit_err <= xgpon_frame_pkg::preamble_threshold);
      corr.delim_hit    <= rx_valid && (rx_data == xgpon_frame_pkg::delimiter_word);
    end
  end

  // payload copy
  always_ff @(posedge axis_aclk_gt_rx_usrclk) begin
    corr.word <= rx_data;
  end

endmodule

// ==== hdl/rx_stream_fifo.sv ====
module rx_stream_fifo (
  input  logic                        axis_aclk_gt_rx_usrclk,
  input  logic                        rst_n,
  input  logic                        wr_en,
  input  rx_stream_pkg::stream_beat_t wr_beat,
  output rx_stream_pkg::line_word_t   m_tdata,
  output logic                        m_tlast,
  output logic                        m_tvalid,
  input  logic                        m_tready,
  output logic                        overflow   // sticky until reset
);

  rx_stream_pkg::stream_beat_t mem [rx_stream_pkg::fifo_depth];

  rx_stream_pkg::fifo_addr_t wr_ptr;
  rx_stream_pkg::fifo_addr_t rd_ptr;
  rx_stream_pkg::fifo_addr_t rd_ptr_next;   // head after this cycle's pop

  logic [$bits(rx_stream_pkg::fifo_addr_t):0] level;           // entries incl head
  logic [$bits(rx_stream_pkg::fifo_addr_t):0] level_after_pop;
  logic full;
  logic push;
  logic pop;

  assign full            = (level == ($bits(level))'(rx_stream_pkg::fifo_depth));
  assign push            = wr_en && !full;         // line can't stall, so drop
  assign pop             = m_tvalid && m_tready;   // stream handshake
  assign rd_ptr_next     = pop ? rd_ptr + 1'b1 : rd_ptr;
  assign level_after_pop = pop ? level - 1'b1 : level;

  // ------------------------------------------------------------------------
  // storage
  // ------------------------------------------------------------------------
  always_ff @(posedge axis_aclk_gt_rx_usrclk) begin
    if (push) mem[wr_ptr] <= wr_beat;
  end

  // ------------------------------------------------------------------------
  // pointers, level and stream control
  // ------------------------------------------------------------------------
  always_ff @(posedge axis_aclk_gt_rx_usrclk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      level    <= '0;
      m_tvalid <= 1'b0;
      m_tlast  <= 1'b0;
      overflow <= 1'b0;
    end else begin
      rd_ptr <= rd_ptr_next;
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
        level  <= level_after_pop + 1'b1;
      end else begin
        level  <= level_after_pop;
      end
      // a fresh write shows one cycle later, level before the write decides
      m_tvalid <= (level_after_pop != '0);
      m_tlast  <= (level_after_pop != '0) && mem[rd_ptr_next].last; // low when idle
      if (wr_en && full) overflow <= 1'b1;
    end
  end

  // head copy, stalled head keeps rd_ptr and is never overwritten
  always_ff @(posedge axis_aclk_gt_rx_usrclk) begin
    m_tdata <= mem[rd_ptr_next].data;
  end

endmodule

// ==== hdl/rx_stream_pkg.sv ====
package rx_stream_pkg;

  // raw word as it comes off the transceiver
  typedef logic [xgpon_frame_pkg::word_width-1:0] line_word_t;

  // one payload beat headed for the stream output
  typedef struct packed {
    line_word_t data;
    logic       last; // final word of the burst
  } stream_beat_t;

  // ------------------------------------------------------------------------
  // output fifo sizing
  // ------------------------------------------------------------------------
  localparam int fifo_depth = 32;

  // pointer wraps naturally at fifo_depth
  typedef logic [$clog2(fifo_depth)-1:0] fifo_addr_t;

endpackage

// ==== hdl/xgpon_frame_pkg.sv ====
package xgpon_frame_pkg;

  // ------------------------------------------------------------------------
  // line word and upstream burst framing
  // ------------------------------------------------------------------------
  localparam int word_width = 32;                      // raw gt rx word
  localparam int dist_width = $clog2(word_width + 1);  // holds 0..32 bit errors

  localparam logic [word_width-1:0] sync_word      = 32'h05560556; // repeated preamble
  localparam logic [word_width-1:0] delimiter_word = 32'hB3C0A5F1; // must match exactly

  localparam int preamble_threshold = 6;  // max bit errors still counted as preamble
  localparam int preamble_min       = 4;  // preamble words in a row to arm
  localparam int delim_window       = 8;  // valid words allowed before the delimiter
  localparam int burst_words        = 16; // fixed payload length

  // one shared down-counter times every phase
  localparam int count_width = 5;

  // ------------------------------------------------------------------------
  // counter load values per phase
  // ------------------------------------------------------------------------
  // first preamble word is taken in hunt, last one is seen while done is high
  localparam logic [count_width-1:0] preamble_load = count_width'(preamble_min - 2);
  localparam logic [count_width-1:0] delim_load    = count_width'(delim_window);
  // done marks the final payload word
  localparam logic [count_width-1:0] payload_load  = count_width'(burst_words - 1);

endpackage

// ==== tests/burst_rx_assertions.sv ====
module burst_rx_assertions (
  input logic                      axis_aclk_gt_rx_usrclk,
  input logic                      rst_n,
  input rx_stream_pkg::line_word_t m_tdata,
  input logic                      m_tlast,
  input logic                      m_tvalid,
  input logic                      m_tready,
  input logic                      burst_start,
  input logic                      overflow
);

  // --------------------------------------------------------------------------
  // stream output protocol
  // --------------------------------------------------------------------------
  tlast_with_tvalid: assert property (
    @(posedge axis_aclk_gt_rx_usrclk) disable iff (!rst_n) m_tlast |-> m_tvalid
  ) else $error("m_tlast high while m_tvalid is low");

  // stalled beat holds data and last
  hold_while_stalled: assert property (
    @(posedge axis_aclk_gt_rx_usrclk) disable iff (!rst_n)
      (m_tvalid && !m_tready) |=> ($stable(m_tdata) && $stable(m_tlast))
  ) else $error("m_tdata or m_tlast changed during a stall");

  // --------------------------------------------------------------------------
  // status
  // --------------------------------------------------------------------------
  start_one_cycle: assert property (
    @(posedge axis_aclk_gt_rx_usrclk) disable iff (!rst_n) burst_start |=> !burst_start
  ) else $error("burst_start high for two cycles in a row");

  overflow_sticky: assert property (
    @(posedge axis_aclk_gt_rx_usrclk) disable iff (!rst_n) overflow |=> overflow
  ) else $error("overflow fell without a reset");

endmodule

// ==== tests/tb_burst_rx.sv ====
module tb_burst_rx;

  logic                        axis_aclk_gt_rx_usrclk;
  logic                        rst_n;
  rx_stream_pkg::line_word_t   rx_data;
  logic                        rx_valid;
  rx_stream_pkg::line_word_t   m_tdata;
  logic                        m_tlast;
  logic                        m_tvalid;
  logic                        m_tready;
  logic                        burst_start;
  logic                        overflow;

  typedef enum {m_hunt, m_pre, m_delim, m_pay} mdl_state_t;

  mdl_state_t  mdl_state;        // framing model, owned by the stimulus process
  int          run_len;          // preamble words in the current run
  int          wait_len;         // non-delimiter words since arming
  int          pay_idx;          // payload words so far
  int          exp_starts;
  int          seen_starts;
  logic        exp_overflow;
  int          ready_mode;       // 0 low, 1 high, 2 random
  int unsigned cycles;
  int unsigned cycle_limit;
  string       test_name;

  logic                        mdl_wr;      // word on rx_data is a payload write
  rx_stream_pkg::stream_beat_t mdl_beat;
  logic                        pipe_wr;     // same write, correlator stage
  rx_stream_pkg::stream_beat_t pipe_beat;
  rx_stream_pkg::stream_beat_t exp_q[$];   // mirrors fifo contents

  burst_rx_top dut (.*);

  bind burst_rx_top burst_rx_assertions u_assertions (
    .axis_aclk_gt_rx_usrclk (axis_aclk_gt_rx_usrclk),
    .rst_n                  (rst_n),
    .m_tdata                (m_tdata),
    .m_tlast                (m_tlast),
    .m_tvalid               (m_tvalid),
    .m_tready               (m_tready),
    .burst_start            (burst_start),
    .overflow               (overflow)
  );

  initial begin
    axis_aclk_gt_rx_usrclk = 1'b0;
    forever #10 axis_aclk_gt_rx_usrclk = ~axis_aclk_gt_rx_usrclk;
  end

  // --------------------------------------------------------------------------
  // compare tasks, first mismatch ends the run
  // --------------------------------------------------------------------------
  task automatic check_word(input string name, input rx_stream_pkg::line_word_t exp,
                            input rx_stream_pkg::line_word_t act);
    if (exp !== act) begin
      $display("[ERROR] %s: m_tdata expected %h, actual %h", name, exp, act);
      $display("Test failures found");
      $fatal(1);
    end
  endtask

  task automatic check_last(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("[ERROR] %s: m_tlast expected %b, actual %b", name, exp, act);
      $display("Test failures found");
      $fatal(1);
    end
  endtask

  task automatic check_starts(input string name, input int exp, input int act);
    if (exp != act) begin
      $display("[ERROR] %s: burst_start count expected %0d, actual %0d", name, exp, act);
      $display("Test failures found");
      $fatal(1);
    end
  endtask

  task automatic check_overflow(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("[ERROR] %s: overflow expected %b, actual %b", name, exp, act);
      $display("Test failures found");
      $fatal(1);
    end
  endtask

  // --------------------------------------------------------------------------
  // framing model, one call per driven word
  // --------------------------------------------------------------------------
  task automatic model_step(input rx_stream_pkg::line_word_t d, input logic v,
                            output logic wr, output rx_stream_pkg::stream_beat_t beat);
    logic pre_hit;
    pre_hit   = v && ($countones(d ^ xgpon_frame_pkg::sync_word)
                      <= xgpon_frame_pkg::preamble_threshold);
    wr        = 1'b0;
    beat.data = d;
    beat.last = 1'b0;
    case (mdl_state)
      m_hunt: begin
        if (pre_hit) begin
          run_len   = 1;
          mdl_state = m_pre;
        end
      end
      m_pre: begin
        if (!pre_hit) begin
          mdl_state = m_hunt;       // idle or bad word breaks the run
        end else begin
          run_len++;
          if (run_len == xgpon_frame_pkg::preamble_min) begin
            wait_len  = 0;
            mdl_state = m_delim;
          end
        end
      end
      m_delim: begin
        if (v && d == xgpon_frame_pkg::delimiter_word) begin
          exp_starts++;
          pay_idx   = 0;
          mdl_state = m_pay;
        end else if (v) begin
          wait_len++;
          if (wait_len > xgpon_frame_pkg::delim_window) mdl_state = m_hunt;
        end
      end
      default: begin
        if (v) begin
          pay_idx++;
          wr        = 1'b1;
          beat.last = (pay_idx == xgpon_frame_pkg::burst_words);
          if (beat.last) mdl_state = m_hunt;
        end
      end
    endcase
  endtask

  // --------------------------------------------------------------------------
  // stimulus
  // --------------------------------------------------------------------------
  task automatic send_word(input rx_stream_pkg::line_word_t d, input logic v);
    logic                        wr;
    rx_stream_pkg::stream_beat_t beat;
    model_step(d, v, wr, beat);
    @(posedge axis_aclk_gt_rx_usrclk);
    rx_data  <= d;
    rx_valid <= v;
    mdl_wr   <= wr;
    mdl_beat <= beat;
    if (ready_mode == 2) m_tready <= ($urandom_range(1, 0) == 1);
    else                 m_tready <= (ready_mode == 1);
  endtask

  // n distinct bit errors against w
  function automatic rx_stream_pkg::line_word_t flip_bits(input rx_stream_pkg::line_word_t w,
                                                          input int n);
    rx_stream_pkg::line_word_t mask;
    int                        idx;
    mask = '0;
    while ($countones(mask) < n) begin
      idx       = $urandom_range(xgpon_frame_pkg::word_width - 1, 0);
      mask[idx] = 1'b1;
    end
    return w ^ mask;
  endfunction

  // idle gap, preamble run, filler, delimiter, payload with optional idle holes
  task automatic send_burst(input int gap, input int n_pre, input int bad_at,
                            input int n_fill, input int hole_pct);
    rx_stream_pkg::line_word_t w;
    repeat (gap) send_word($urandom(), 1'b0);
    for (int i = 0; i < n_pre; i++) begin
      if (i == bad_at) w = flip_bits(xgpon_frame_pkg::sync_word, $urandom_range(10, 7));
      else w = flip_bits(xgpon_frame_pkg::sync_word,
                         $urandom_range(xgpon_frame_pkg::preamble_threshold, 0));
      send_word(w, 1'b1);
    end
    for (int i = 0; i < n_fill; i++) send_word($urandom(), 1'b1);
    send_word(xgpon_frame_pkg::delimiter_word, 1'b1);
    for (int i = 0; i < xgpon_frame_pkg::burst_words; i++) begin
      if ($urandom_range(99, 0) < hole_pct) send_word($urandom(), 1'b0);
      send_word($urandom(), 1'b1);
    end
  endtask

  // ready high until every accepted word is out, then compare status
  task automatic drain_and_check();
    ready_mode = 1;
    repeat (4) send_word($urandom(), 1'b0);   // pending writes land first
    @(negedge axis_aclk_gt_rx_usrclk);
    while (exp_q.size() != 0) begin
      send_word($urandom(), 1'b0);
      @(negedge axis_aclk_gt_rx_usrclk);
    end
    repeat (2) send_word($urandom(), 1'b0);
    @(negedge axis_aclk_gt_rx_usrclk);
    check_starts(test_name, exp_starts, seen_starts);
    check_overflow(test_name, exp_overflow, overflow);
  endtask

  // --------------------------------------------------------------------------
  // output monitor and fifo occupancy, pop before push like the hardware
  // --------------------------------------------------------------------------
  always @(posedge axis_aclk_gt_rx_usrclk) begin
    logic                        full;
    rx_stream_pkg::stream_beat_t head;
    if (rst_n) begin
      full = (exp_q.size() == rx_stream_pkg::fifo_depth);
      if (burst_start) seen_starts++;
      if (m_tvalid && m_tready) begin
        if (exp_q.size() == 0) begin
          $display("output beat in %s with no payload word left to deliver", test_name);
          $display("Test failures found");
          $fatal(1);
        end else begin
          head = exp_q.pop_front();
          check_word(test_name, head.data, m_tdata);
          check_last(test_name, head.last, m_tlast);
        end
      end
      if (pipe_wr && full) exp_overflow = 1'b1;   // dropped
      else if (pipe_wr)    exp_q.push_back(pipe_beat);
    end
    pipe_wr   <= mdl_wr;
    pipe_beat <= mdl_beat;
  end

  always @(posedge axis_aclk_gt_rx_usrclk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("timeout, the run went past %0d cycles without finishing", cycle_limit);
      $display("Test failures found");
      $fatal(1);
    end
  end

  initial begin
    rst_n        = 1'b0;
    rx_data      = '0;
    rx_valid     = 1'b0;
    m_tready     = 1'b0;
    mdl_wr       = 1'b0;
    mdl_beat     = '0;
    pipe_wr      = 1'b0;
    mdl_state    = m_hunt;
    exp_starts   = 0;
    seen_starts  = 0;
    exp_overflow = 1'b0;
    ready_mode   = 1;
    cycles       = 0;
    // 18 bursts of at most 64 words, 6 drains of depth + 8
    cycle_limit  = 2 * (18 * 64 + 6 * (rx_stream_pkg::fifo_depth + 8));
    void'($urandom(32'h65dd));
    repeat (3) @(posedge axis_aclk_gt_rx_usrclk);
    rst_n <= 1'b1;

    test_name = "clean_bursts";
    repeat (3) send_burst($urandom_range(8, 1), $urandom_range(8, 4), -1, 0, 0);
    drain_and_check();

    test_name = "preamble_errors";
    send_burst(3, 4, 2, 0, 0);   // broken run, nothing out
    send_burst(3, 7, 2, 0, 0);   // fresh run of four after the bad word
    drain_and_check();

    test_name = "delim_timeout";
    send_burst(3, 4, -1, xgpon_frame_pkg::delim_window + 1, 0);
    send_burst(3, 4, -1, xgpon_frame_pkg::delim_window, 0);  // last word still in window
    drain_and_check();

    test_name  = "backpressure";
    ready_mode = 2;
    repeat (5) send_burst(12, $urandom_range(6, 4), -1, 0, 0);
    drain_and_check();

    test_name = "valid_gaps";
    repeat (3) send_burst($urandom_range(4, 1), 4, -1, 0, 30);
    drain_and_check();

    test_name  = "overflow";
    ready_mode = 0;
    repeat (3) send_burst(2, 4, -1, 0, 0);
    drain_and_check();

    $display("All tests passed!");
    $finish;
  end

endmodule
